/* hw/archie_settings.svh */
`ifndef ARCHIE_SETTINGS_SVH
`define ARCHIE_SETTINGS_SVH

// clock enables, in clk_sys cycles
`define ARCHIE_CLKEN_PERIOD 20
`define ARCHIE_CLK8M_STEP 5

// busy cycles allowed after a reconfig request
`define ARCHIE_RECONFIG_TIMEOUT 1000

// back porch widths in clk_sys cycles
`define ARCHIE_BLANK_TV 256
`define ARCHIE_BLANK_VGA 64

// download slots holding a ROM image
`define ARCHIE_ROM_INDEX_A 1
`define ARCHIE_ROM_INDEX_B 2

// bus widths
`define ARCHIE_RAM_AW 24
`define ARCHIE_DL_AW 24

`endif

/* hw/archie_mem_pkg.sv */
`default_nettype none

`include "archie_settings.svh"

package archie_mem_pkg;

	// one RAM data word
	typedef logic [31:0] word_t;

	// byte lane enables
	typedef logic [3:0] byte_sel_t;

	// byte address into RAM
	typedef logic [`ARCHIE_RAM_AW-1:0] ram_addr_t;

	// download payload and slot
	typedef logic [7:0] dl_byte_t;
	typedef logic [7:0] dl_index_t;

	// strobe/ack request, stb held until ack
	typedef struct packed {
		logic      stb;
		logic      we;
		byte_sel_t sel;
		ram_addr_t addr;
		word_t     data;
	} mem_req_t;

endpackage

`default_nettype wire

/* hw/archie_video_pkg.sv */
`default_nettype none

package archie_video_pkg;

	// one colour channel
	typedef logic [3:0] colour_t;

	typedef struct packed {
		colour_t r;
		colour_t g;
		colour_t b;
		logic    hs;
		logic    vs;
	} video_t;

	// pixel base clock select from the core
	// 00 and 11 are TV modes, 01 and 10 VGA
	typedef enum logic [1:0] {
		PIX_24M     = 2'b00,
		PIX_25M     = 2'b01,
		PIX_36M     = 2'b10,
		PIX_24M_ALT = 2'b11
	} pix_base_t;

	// video PLL reconfiguration sequencer
	typedef enum logic [1:0] {
		RC_IDLE,
		RC_SETTLE,
		RC_WAIT_IDLE,
		RC_RUN
	} reconfig_state_t;

endpackage

`default_nettype wire

/* hw/clock_enable_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "archie_settings.svh"

module clock_enable_gen (
	input  wire  clk_sys,
	input  wire  rst_i,
	output logic clk2m_en_o,
	output logic clk8m_en_o
);

	localparam logic [4:0] LAST = 5'(`ARCHIE_CLKEN_PERIOD - 1);
	localparam logic [4:0] STEP = 5'(`ARCHIE_CLK8M_STEP);

	logic [4:0] cnt;

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			cnt <= '0;
			clk2m_en_o <= 1'b0;
			clk8m_en_o <= 1'b0;
		end else begin
			if (cnt == LAST)
				cnt <= '0;
			else
				cnt <= cnt + 5'd1;

			clk2m_en_o <= (cnt == 5'd0);
			// four evenly spaced pulses, first one shared with 2 MHz
			clk8m_en_o <= (cnt == 5'd0) || (cnt == STEP) ||
				(cnt == 5'(2 * STEP)) || (cnt == 5'(3 * STEP));
		end
	end

endmodule

`default_nettype wire

/* hw/pll_reconfig_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "archie_settings.svh"

module pll_reconfig_ctrl (
	input  wire                        clk_sys,
	input  wire                        rst_i,
	input  archie_video_pkg::pix_base_t pix_base_i,
	input  wire                        pll_busy_i,
	output logic                       pll_rom_write_o,
	output logic                       pll_reconfig_o,
	output logic                       pll_reconfig_reset_o,
	output logic                       pix_clk_ena_o
);

	localparam logic [9:0] TIMEOUT = 10'(`ARCHIE_RECONFIG_TIMEOUT);

	archie_video_pkg::reconfig_state_t state;
	archie_video_pkg::pix_base_t       sel_q;
	logic [9:0]                        timeout_cnt;

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			state <= archie_video_pkg::RC_IDLE;
			sel_q <= archie_video_pkg::PIX_36M;
			timeout_cnt <= '0;
			pll_rom_write_o <= 1'b0;
			pll_reconfig_o <= 1'b0;
			pll_reconfig_reset_o <= 1'b0;
			pix_clk_ena_o <= 1'b1;
		end else begin
			// strobes last one cycle
			pll_rom_write_o <= 1'b0;
			pll_reconfig_o <= 1'b0;
			pll_reconfig_reset_o <= 1'b0;

			case (state)
				archie_video_pkg::RC_IDLE: begin
					pix_clk_ena_o <= 1'b1;
					sel_q <= pix_base_i;
					if (pix_base_i != sel_q) begin
						// stop the pixel clock and load the new settings
						pix_clk_ena_o <= 1'b0;
						pll_rom_write_o <= 1'b1;
						state <= archie_video_pkg::RC_SETTLE;
					end
				end
				archie_video_pkg::RC_SETTLE: begin
					state <= archie_video_pkg::RC_WAIT_IDLE;
				end
				archie_video_pkg::RC_WAIT_IDLE: begin
					if (!pll_busy_i) begin
						pll_reconfig_o <= 1'b1;
						timeout_cnt <= TIMEOUT;
						state <= archie_video_pkg::RC_RUN;
					end
				end
				archie_video_pkg::RC_RUN: begin
					timeout_cnt <= timeout_cnt - 10'd1;
					// PLL never came back, kick its reconfig block
					if (timeout_cnt == 10'd1) begin
						pll_reconfig_reset_o <= 1'b1;
						state <= archie_video_pkg::RC_IDLE;
					end
					if (!pll_reconfig_o && !pll_busy_i)
						state <= archie_video_pkg::RC_IDLE;
				end
				default: begin
					state <= archie_video_pkg::RC_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/back_porch_blanker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "archie_settings.svh"

module back_porch_blanker (
	input  wire                         clk_sys,
	input  wire                         rst_i,
	input  archie_video_pkg::pix_base_t pix_base_i,
	input  wire                         ce_pix_i,
	input  archie_video_pkg::video_t    core_video_i,
	output archie_video_pkg::video_t    video_o
);

	localparam logic [7:0] SAT_TV = 8'(`ARCHIE_BLANK_TV - 1);
	localparam logic [7:0] SAT_VGA = 8'(`ARCHIE_BLANK_VGA - 1);

	logic [7:0] line_cnt;
	logic       tv_mode;
	logic       porch_done;

	always_comb begin
		tv_mode = (pix_base_i == archie_video_pkg::PIX_24M) ||
			(pix_base_i == archie_video_pkg::PIX_24M_ALT);
		porch_done = tv_mode ? (line_cnt >= SAT_TV) : (line_cnt >= SAT_VGA);
	end

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			line_cnt <= '0;
			video_o <= '0;
		end else begin
			if (!porch_done)
				line_cnt <= line_cnt + 8'd1;
			// restart at every sync pulse
			if (!video_o.hs)
				line_cnt <= '0;

			if (ce_pix_i) begin
				video_o.hs <= core_video_i.hs;
				video_o.vs <= core_video_i.vs;
				if (porch_done) begin
					video_o.r <= core_video_i.r;
					video_o.g <= core_video_i.g;
					video_o.b <= core_video_i.b;
				end else begin
					video_o.r <= '0;
					video_o.g <= '0;
					video_o.b <= '0;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hw/boot_loader_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "archie_settings.svh"

module boot_loader_port (
	input  wire                         clk_sys,
	input  wire                         rst_i,
	input  wire                         dl_active_i,
	input  archie_mem_pkg::dl_index_t   dl_index_i,
	input  wire                         dl_wr_i,
	input  wire [`ARCHIE_DL_AW-1:0]     dl_addr_i,
	input  archie_mem_pkg::dl_byte_t    dl_data_i,
	input  archie_mem_pkg::mem_req_t    core_req_i,
	output logic                        core_ack_o,
	output archie_mem_pkg::mem_req_t    ram_req_o,
	input  wire                         ram_ack_i,
	input  wire                         ram_ready_i,
	input  wire                         reset_button_i,
	output logic                        core_reset_o
);

	logic                           loader_active;
	logic                           loader_active_q;
	logic                           loader_stb;
	logic                           rom_ready;
	logic [`ARCHIE_DL_AW-1:0]       dl_addr_q;
	archie_mem_pkg::dl_byte_t       dl_data_q;
	archie_mem_pkg::ram_addr_t      loader_addr;
	archie_mem_pkg::byte_sel_t      loader_sel;

	// only ROM slots take over the RAM port
	assign loader_active = dl_active_i &&
		((dl_index_i == archie_mem_pkg::dl_index_t'(`ARCHIE_ROM_INDEX_A)) ||
		(dl_index_i == archie_mem_pkg::dl_index_t'(`ARCHIE_ROM_INDEX_B)));

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			loader_active_q <= 1'b0;
			loader_stb <= 1'b0;
			rom_ready <= 1'b0;
		end else begin
			loader_active_q <= loader_active;
			// end of a ROM download, sticky until reset
			if (loader_active_q && !loader_active)
				rom_ready <= 1'b1;
			if (dl_wr_i)
				loader_stb <= 1'b1;
			else if (ram_ack_i)
				loader_stb <= 1'b0;
		end
	end

	// byte and address held for the whole strobe
	always_ff @(posedge clk_sys) begin
		if (dl_wr_i) begin
			dl_addr_q <= dl_addr_i;
			dl_data_q <= dl_data_i;
		end
	end

	assign loader_addr = archie_mem_pkg::ram_addr_t'(dl_addr_q);
	assign loader_sel = archie_mem_pkg::byte_sel_t'(4'b0001 << loader_addr[1:0]);

	always_comb begin
		if (loader_active) begin
			ram_req_o.stb = loader_stb;
			ram_req_o.we = 1'b1;
			ram_req_o.sel = loader_sel;
			ram_req_o.addr = {loader_addr[`ARCHIE_RAM_AW-1:2], 2'b00};
			ram_req_o.data = {4{dl_data_q}};
			core_ack_o = 1'b0;
		end else begin
			ram_req_o = core_req_i;
			ram_req_o.addr = {core_req_i.addr[`ARCHIE_RAM_AW-1:2], 2'b00};
			core_ack_o = ram_ack_i;
		end
	end

	assign core_reset_o = !ram_ready_i || !rom_ready || reset_button_i;

endmodule

`default_nettype wire

/* hw/archie_glue_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "archie_settings.svh"

module archie_glue_top (
	input  wire                         clk_sys,
	input  wire                         rst_i,
	output logic                        clk2m_en_o,
	output logic                        clk8m_en_o,
	input  archie_video_pkg::pix_base_t pix_base_i,
	input  wire                         pll_busy_i,
	output logic                        pll_rom_write_o,
	output logic                        pll_reconfig_o,
	output logic                        pll_reconfig_reset_o,
	output logic                        pix_clk_ena_o,
	input  wire                         ce_pix_i,
	input  archie_video_pkg::video_t    core_video_i,
	output archie_video_pkg::video_t    video_o,
	input  wire                         dl_active_i,
	input  archie_mem_pkg::dl_index_t   dl_index_i,
	input  wire                         dl_wr_i,
	input  wire [`ARCHIE_DL_AW-1:0]     dl_addr_i,
	input  archie_mem_pkg::dl_byte_t    dl_data_i,
	input  archie_mem_pkg::mem_req_t    core_req_i,
	output logic                        core_ack_o,
	output archie_mem_pkg::mem_req_t    ram_req_o,
	input  wire                         ram_ack_i,
	input  wire                         ram_ready_i,
	input  wire                         reset_button_i,
	output logic                        core_reset_o
);

	clock_enable_gen u_clkens (
		.clk_sys    (clk_sys),
		.rst_i      (rst_i),
		.clk2m_en_o (clk2m_en_o),
		.clk8m_en_o (clk8m_en_o)
	);

	// video PLL is rewritten outside, only its busy line comes back
	pll_reconfig_ctrl u_pll_seq (
		.clk_sys              (clk_sys),
		.rst_i                (rst_i),
		.pix_base_i           (pix_base_i),
		.pll_busy_i           (pll_busy_i),
		.pll_rom_write_o      (pll_rom_write_o),
		.pll_reconfig_o       (pll_reconfig_o),
		.pll_reconfig_reset_o (pll_reconfig_reset_o),
		.pix_clk_ena_o        (pix_clk_ena_o)
	);

	back_porch_blanker u_blanker (
		.clk_sys      (clk_sys),
		.rst_i        (rst_i),
		.pix_base_i   (pix_base_i),
		.ce_pix_i     (ce_pix_i),
		.core_video_i (core_video_i),
		.video_o      (video_o)
	);

	boot_loader_port u_loader (
		.clk_sys        (clk_sys),
		.rst_i          (rst_i),
		.dl_active_i    (dl_active_i),
		.dl_index_i     (dl_index_i),
		.dl_wr_i        (dl_wr_i),
		.dl_addr_i      (dl_addr_i),
		.dl_data_i      (dl_data_i),
		.core_req_i     (core_req_i),
		.core_ack_o     (core_ack_o),
		.ram_req_o      (ram_req_o),
		.ram_ack_i      (ram_ack_i),
		.ram_ready_i    (ram_ready_i),
		.reset_button_i (reset_button_i),
		.core_reset_o   (core_reset_o)
	);

endmodule

`default_nettype wire

/* testbench/archie_glue_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "archie_settings.svh"

module archie_glue_checker (
	input  wire                         clk_sys,
	input  wire                         rst_i,
	input  wire                         clk2m_en_o,
	input  wire                         clk8m_en_o,
	input  archie_video_pkg::pix_base_t pix_base_i,
	input  wire                         pll_busy_i,
	input  wire                         pll_rom_write_o,
	input  wire                         pll_reconfig_o,
	input  wire                         pll_reconfig_reset_o,
	input  wire                         pix_clk_ena_o,
	input  wire                         ce_pix_i,
	input  archie_video_pkg::video_t    core_video_i,
	input  archie_video_pkg::video_t    video_o,
	input  wire                         dl_active_i,
	input  archie_mem_pkg::dl_index_t   dl_index_i,
	input  wire                         dl_wr_i,
	input  wire [`ARCHIE_DL_AW-1:0]     dl_addr_i,
	input  archie_mem_pkg::dl_byte_t    dl_data_i,
	input  archie_mem_pkg::mem_req_t    core_req_i,
	input  wire                         core_ack_o,
	input  archie_mem_pkg::mem_req_t    ram_req_o,
	input  wire                         ram_ack_i,
	input  wire                         ram_ready_i,
	input  wire                         reset_button_i,
	input  wire                         core_reset_o,
	output int                          error_count_o
);

	// clock enable model
	int en_cnt;
	logic exp_2m;
	logic exp_8m;

	// sequencer model, phase 0 idle, 1 settle, 2 wait for idle PLL, 3 running
	int rc_phase;
	int run_cycles;
	archie_video_pkg::pix_base_t exp_sel;
	logic exp_rw;
	logic exp_rc;
	logic exp_rr;
	logic exp_ena;

	// blanker model
	int line_cnt;
	int sat_point;
	archie_video_pkg::video_t exp_video;

	// loader model
	logic exp_stb;
	logic act_q;
	logic exp_rom_ready;
	logic [`ARCHIE_DL_AW-1:0] wr_addr;
	archie_mem_pkg::dl_byte_t wr_data;
	logic loading;
	archie_mem_pkg::mem_req_t exp_req;
	logic exp_core_ack;

	always_comb begin
		loading = dl_active_i && (dl_index_i == `ARCHIE_ROM_INDEX_A ||
			dl_index_i == `ARCHIE_ROM_INDEX_B);
		if (pix_base_i == archie_video_pkg::PIX_24M || pix_base_i == archie_video_pkg::PIX_24M_ALT)
			sat_point = `ARCHIE_BLANK_TV - 1;
		else
			sat_point = `ARCHIE_BLANK_VGA - 1;
		if (loading) begin
			exp_req.stb = exp_stb;
			exp_req.we = 1'b1;
			exp_req.sel = 4'b0001 << wr_addr[1:0];
			exp_req.addr = wr_addr[`ARCHIE_RAM_AW-1:0] & ~24'h3;
			exp_req.data = {wr_data, wr_data, wr_data, wr_data};
			exp_core_ack = 1'b0;
		end else begin
			exp_req = core_req_i;
			exp_req.addr = core_req_i.addr & ~24'h3;
			exp_core_ack = ram_ack_i;
		end
	end

	always @(posedge clk_sys) begin
		if (dl_wr_i) begin
			wr_addr <= dl_addr_i;
			wr_data <= dl_data_i;
		end
		if (rst_i) begin
			en_cnt <= 0;
			exp_2m <= 1'b0;
			exp_8m <= 1'b0;
			rc_phase <= 0;
			run_cycles <= 0;
			exp_sel <= archie_video_pkg::PIX_36M;
			exp_rw <= 1'b0;
			exp_rc <= 1'b0;
			exp_rr <= 1'b0;
			exp_ena <= 1'b1;
			line_cnt <= 0;
			exp_video <= '0;
			exp_stb <= 1'b0;
			act_q <= 1'b0;
			exp_rom_ready <= 1'b0;
		end else begin
			exp_2m <= (en_cnt == 0);
			exp_8m <= (en_cnt % `ARCHIE_CLK8M_STEP == 0);
			en_cnt <= (en_cnt + 1) % `ARCHIE_CLKEN_PERIOD;

			exp_rw <= 1'b0;
			exp_rc <= 1'b0;
			exp_rr <= 1'b0;
			case (rc_phase)
				0: begin
					exp_ena <= 1'b1;
					if (pix_base_i != exp_sel) begin
						exp_sel <= pix_base_i;
						exp_rw <= 1'b1;
						exp_ena <= 1'b0;
						rc_phase <= 1;
					end
				end
				1: rc_phase <= 2;
				2: begin
					if (!pll_busy_i) begin
						exp_rc <= 1'b1;
						run_cycles <= 0;
						rc_phase <= 3;
					end
				end
				default: begin
					run_cycles <= run_cycles + 1;
					if (run_cycles == `ARCHIE_RECONFIG_TIMEOUT - 1) begin
						exp_rr <= 1'b1;
						rc_phase <= 0;
					end else if (run_cycles > 0 && !pll_busy_i) begin
						rc_phase <= 0;
					end
				end
			endcase

			if (!exp_video.hs)
				line_cnt <= 0;
			else if (line_cnt < sat_point)
				line_cnt <= line_cnt + 1;
			if (ce_pix_i) begin
				exp_video.hs <= core_video_i.hs;
				exp_video.vs <= core_video_i.vs;
				exp_video.r <= (line_cnt >= sat_point) ? core_video_i.r : 4'h0;
				exp_video.g <= (line_cnt >= sat_point) ? core_video_i.g : 4'h0;
				exp_video.b <= (line_cnt >= sat_point) ? core_video_i.b : 4'h0;
			end

			act_q <= loading;
			if (act_q && !loading)
				exp_rom_ready <= 1'b1;
			if (dl_wr_i)
				exp_stb <= 1'b1;
			else if (ram_ack_i)
				exp_stb <= 1'b0;
		end
	end

	task automatic check_value(input string name, input logic [63:0] exp_v,
		input logic [63:0] act_v);
		if (act_v !== exp_v) begin
			error_count_o = error_count_o + 1;
			$display("Fail %s expected %h actual %h at %0t", name, exp_v, act_v, $time);
		end
	endtask

	initial error_count_o = 0;

	// outputs have settled by the falling edge
	always @(negedge clk_sys) begin
		if (!rst_i) begin
			check_value("clk2m_en_o", exp_2m, clk2m_en_o);
			check_value("clk8m_en_o", exp_8m, clk8m_en_o);
			check_value("pll_rom_write_o", exp_rw, pll_rom_write_o);
			check_value("pll_reconfig_o", exp_rc, pll_reconfig_o);
			check_value("pll_reconfig_reset_o", exp_rr, pll_reconfig_reset_o);
			check_value("pix_clk_ena_o", exp_ena, pix_clk_ena_o);
			check_value("video_o", exp_video, video_o);
			check_value("ram_req_o", exp_req, ram_req_o);
			check_value("core_ack_o", exp_core_ack, core_ack_o);
			check_value("core_reset_o", !ram_ready_i || !exp_rom_ready || reset_button_i,
				core_reset_o);
		end
	end

endmodule

`default_nettype wire

/* testbench/tb_archie_glue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "archie_settings.svh"

module tb_archie_glue;

	localparam int RECONFIGS = 6;
	localparam int LINES = 3;
	localparam int LINE_LEN = 400;
	localparam int HS_LOW = 8;
	localparam int CORE_REQS = 28;
	localparam int ROM_BYTES = 16;
	localparam int ROM_B_BYTES = 4;
	localparam int RECONFIG_LEN = (RECONFIGS + 3) * 80 + `ARCHIE_RECONFIG_TIMEOUT + 200;
	localparam int VIDEO_LEN = 2 * LINES * LINE_LEN;
	localparam int MEM_LEN = (CORE_REQS + ROM_BYTES + ROM_B_BYTES) * 10 + 100;
	localparam int CYCLE_LIMIT = 40 + RECONFIG_LEN + VIDEO_LEN + MEM_LEN +
		2 * `ARCHIE_RECONFIG_TIMEOUT;

	logic clk_sys = 1'b0;
	logic rst_i;
	logic clk2m_en_o;
	logic clk8m_en_o;
	archie_video_pkg::pix_base_t pix_base_i;
	logic pll_busy_i;
	logic pll_rom_write_o;
	logic pll_reconfig_o;
	logic pll_reconfig_reset_o;
	logic pix_clk_ena_o;
	logic ce_pix_i;
	archie_video_pkg::video_t core_video_i;
	archie_video_pkg::video_t video_o;
	logic dl_active_i;
	archie_mem_pkg::dl_index_t dl_index_i;
	logic dl_wr_i;
	logic [`ARCHIE_DL_AW-1:0] dl_addr_i;
	archie_mem_pkg::dl_byte_t dl_data_i;
	archie_mem_pkg::mem_req_t core_req_i;
	logic core_ack_o;
	archie_mem_pkg::mem_req_t ram_req_o;
	logic ram_ack_i;
	logic ram_ready_i;
	logic reset_button_i;
	logic core_reset_o;
	int error_count_o;

	integer seed;
	int tb_errors = 0;
	int cycles = 0;
	int busy_left;
	int ack_wait;
	logic long_busy;
	logic saw_reset;

	archie_glue_top UUT (.*);
	archie_glue_checker checker_inst (.*);

	always #20 clk_sys = ~clk_sys;

	task automatic report_problem(input string msg);
		tb_errors = tb_errors + 1;
		$display("%s at %0t", msg, $time);
	endtask

	// PLL busy for a random while after every reconfig pulse
	always @(posedge clk_sys) begin
		int hold;
		if (rst_i) begin
			pll_busy_i <= 1'b0;
			busy_left <= 0;
		end else if (pll_reconfig_o) begin
			hold = long_busy ? `ARCHIE_RECONFIG_TIMEOUT + 100 : {$random(seed)} % 21;
			pll_busy_i <= (hold != 0);
			busy_left <= hold;
		end else if (busy_left > 1) begin
			busy_left <= busy_left - 1;
		end else begin
			busy_left <= 0;
			pll_busy_i <= 1'b0;
		end
		if (pll_reconfig_reset_o)
			saw_reset <= 1'b1;
	end

	// RAM acks after 0 to 3 cycles
	always @(posedge clk_sys) begin
		if (rst_i || ram_ack_i) begin
			ram_ack_i <= 1'b0;
			ack_wait <= {$random(seed)} % 4;
		end else if (ram_req_o.stb) begin
			if (ack_wait == 0)
				ram_ack_i <= 1'b1;
			else
				ack_wait <= ack_wait - 1;
		end
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run timed out after %0d cycles", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic change_pix_base(input archie_video_pkg::pix_base_t value);
		int n;
		@(posedge clk_sys);
		pix_base_i <= value;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (!pll_rom_write_o && n < 8);
		if (!pll_rom_write_o)
			report_problem("no PLL ROM write after pixel base change");
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (!pix_clk_ena_o && n < 2 * `ARCHIE_RECONFIG_TIMEOUT);
		if (!pix_clk_ena_o)
			report_problem("pixel clock never re-enabled after reconfiguration");
	endtask

	task automatic wait_ram_ack();
		int n;
		n = 0;
		do begin
			@(posedge clk_sys);
			n++;
		end while (!ram_ack_i && n < 20);
		if (!ram_ack_i)
			report_problem("RAM request never acknowledged");
	endtask

	task automatic core_access();
		archie_mem_pkg::mem_req_t req;
		req.stb = 1'b1;
		req.we = 1'($random(seed));
		req.sel = 4'($random(seed));
		req.addr = 24'($random(seed));
		req.data = 32'($random(seed));
		@(posedge clk_sys);
		core_req_i <= req;
		wait_ram_ack();
		core_req_i.stb <= 1'b0;
	endtask

	task automatic write_rom_byte(input int k);
		@(posedge clk_sys);
		dl_wr_i <= 1'b1;
		dl_addr_i <= 24'('h100 + k * 3 + ({$random(seed)} % 4));
		dl_data_i <= 8'($random(seed));
		@(posedge clk_sys);
		dl_wr_i <= 1'b0;
		wait_ram_ack();
	endtask

	task automatic run_lines(input int count);
		for (int l = 0; l < count; l++) begin
			for (int c = 0; c < LINE_LEN; c++) begin
				@(posedge clk_sys);
				ce_pix_i <= 1'($random(seed));
				core_video_i <= {12'($random(seed)), c >= HS_LOW, l == 0};
			end
		end
	endtask

	initial begin
		seed = 10;
		rst_i = 1'b1;
		pix_base_i = archie_video_pkg::PIX_36M;
		pll_busy_i = 1'b0;
		ram_ack_i = 1'b0;
		ce_pix_i = 1'b0;
		core_video_i = '0;
		dl_active_i = 1'b0;
		dl_index_i = '0;
		dl_wr_i = 1'b0;
		dl_addr_i = '0;
		dl_data_i = '0;
		core_req_i = '0;
		ram_ready_i = 1'b0;
		reset_button_i = 1'b0;
		long_busy = 1'b0;
		saw_reset = 1'b0;
		repeat (8) @(posedge clk_sys);
		rst_i <= 1'b0;
		repeat (30) @(posedge clk_sys);

		for (int i = 0; i < RECONFIGS; i++)
			change_pix_base(archie_video_pkg::pix_base_t'((pix_base_i + 1 +
				{$random(seed)} % 3) % 4));
		// PLL stuck busy past the timeout
		long_busy = 1'b1;
		change_pix_base((pix_base_i == archie_video_pkg::PIX_25M) ?
			archie_video_pkg::PIX_36M : archie_video_pkg::PIX_25M);
		long_busy = 1'b0;
		if (!saw_reset)
			report_problem("no PLL reset pulse while busy stuck high");

		change_pix_base(archie_video_pkg::PIX_24M);
		run_lines(LINES);
		change_pix_base(archie_video_pkg::PIX_25M);
		run_lines(LINES);

		ram_ready_i <= 1'b1;
		for (int i = 0; i < 12; i++)
			core_access();
		// non ROM slot leaves the core on the port
		dl_index_i <= 8'd5;
		dl_active_i <= 1'b1;
		for (int i = 0; i < 8; i++)
			core_access();
		@(posedge clk_sys);
		dl_active_i <= 1'b0;
		dl_index_i <= `ARCHIE_ROM_INDEX_A;
		@(posedge clk_sys);
		dl_active_i <= 1'b1;
		for (int k = 0; k < ROM_BYTES; k++)
			write_rom_byte(k);
		@(posedge clk_sys);
		dl_active_i <= 1'b0;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		if (core_reset_o)
			report_problem("core still in reset after ROM download");
		for (int i = 0; i < 8; i++)
			core_access();
		// second ROM slot takes the port the same way
		@(posedge clk_sys);
		dl_index_i <= `ARCHIE_ROM_INDEX_B;
		@(posedge clk_sys);
		dl_active_i <= 1'b1;
		for (int k = 0; k < ROM_B_BYTES; k++)
			write_rom_byte(k);
		@(posedge clk_sys);
		dl_active_i <= 1'b0;
		repeat (2) @(posedge clk_sys);
		reset_button_i <= 1'b1;
		repeat (3) @(posedge clk_sys);
		reset_button_i <= 1'b0;
		repeat (2) @(posedge clk_sys);
		// RAM drops out of ready on its own
		ram_ready_i <= 1'b0;
		repeat (3) @(posedge clk_sys);
		ram_ready_i <= 1'b1;
		repeat (5) @(posedge clk_sys);

		$display("errors: checker %0d, testbench %0d", error_count_o, tb_errors);
		if (error_count_o == 0 && tb_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hw
hw/archie_mem_pkg.sv
hw/archie_video_pkg.sv
hw/clock_enable_gen.sv
hw/pll_reconfig_ctrl.sv
hw/back_porch_blanker.sv
hw/boot_loader_port.sv
hw/archie_glue_top.sv
testbench/archie_glue_checker.sv
testbench/tb_archie_glue.sv

/* Bender.yml */
package:
  name: archie_glue

sources:
  - include_dirs:
      - hw
    files:
      - hw/archie_mem_pkg.sv
      - hw/archie_video_pkg.sv
      - hw/clock_enable_gen.sv
      - hw/pll_reconfig_ctrl.sv
      - hw/back_porch_blanker.sv
      - hw/boot_loader_port.sv
      - hw/archie_glue_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/archie_glue_checker.sv
      - testbench/tb_archie_glue.sv
